/* sources.f */
prf_cfg_pkg.sv
prf_state_pkg.sv
prf_entry.sv
prf_alloc.sv
prf_free_ctrl.sv
prf_read_port.sv
prf.sv
tb_prf_checks.sv
tb_prf.sv

/* Bender.yml */
package:
  name: prf

sources:
  # packages first, the modules import them
  - prf_cfg_pkg.sv
  - prf_state_pkg.sv
  - prf_entry.sv
  - prf_alloc.sv
  - prf_free_ctrl.sv
  - prf_read_port.sv
  - prf.sv
  - target: simulation
    files:
      - tb_prf_checks.sv
      - tb_prf.sv

/* tb_prf.sv */
// testbench top for the register file, runs directed and random tests against a reference model
`timescale 1ns/1ps

module tb_prf;
	import prf_cfg_pkg::*;
	import prf_state_pkg::*;

	localparam int TAG_W         = $clog2(PRF_SIZE);
	localparam int FILL_TIMEOUT  = 2 * PRF_SIZE;   // cycles allowed to drain the free list
	localparam int RANDOM_CYCLES = 400;

	logic                            clock = 1'b0;
	logic                            rst_n;
	logic                            alloc_req0;
	logic                            alloc_req1;
	logic                            alloc0_valid;
	logic [TAG_W-1:0]                alloc0_tag;
	logic                            alloc1_valid;
	logic [TAG_W-1:0]                alloc1_tag;
	logic                            prf_full;
	logic                            cdb0_valid;
	logic [TAG_W-1:0]                cdb0_tag;
	logic [DATA_W-1:0]               cdb0_value;
	logic                            cdb1_valid;
	logic [TAG_W-1:0]                cdb1_tag;
	logic [DATA_W-1:0]               cdb1_value;
	logic                            free0_valid;
	logic [TAG_W-1:0]                free0_tag;
	logic                            free1_valid;
	logic [TAG_W-1:0]                free1_tag;
	logic                            flush_valid;
	logic [PRF_SIZE-1:0]             flush_list;
	logic [5:0][TAG_W-1:0]           rd_tag;      // inst0 a/b, inst1 a/b, retire 0/1
	wire  [5:0][DATA_W-1:0]          rd_value;
	wire  [3:0]                      rd_valid;

	// reference model, one state and one value per entry
	entry_state_e                    m_state [PRF_SIZE];
	logic [DATA_W-1:0]               m_value [PRF_SIZE];
	logic                            exp_alloc0_valid;
	logic [TAG_W-1:0]                exp_alloc0_tag;
	logic                            exp_alloc1_valid;
	logic [TAG_W-1:0]                exp_alloc1_tag;
	logic                            exp_full;
	logic [5:0][DATA_W-1:0]          exp_value;
	logic [3:0]                      exp_valid;

	int tb_errors       = 0;
	int errors_at_start = 0;
	int tests_done      = 0;

	always #50 clock = ~clock;

	prf #(
		.PRF_SIZE (PRF_SIZE),
		.ZERO_TAG (ZERO_TAG)
	) i_dut (
		.inst0_opa_tag   (rd_tag[0]),
		.inst0_opb_tag   (rd_tag[1]),
		.inst1_opa_tag   (rd_tag[2]),
		.inst1_opb_tag   (rd_tag[3]),
		.retire0_tag     (rd_tag[4]),
		.retire1_tag     (rd_tag[5]),
		.inst0_opa_value (rd_value[0]),
		.inst0_opb_value (rd_value[1]),
		.inst1_opa_value (rd_value[2]),
		.inst1_opb_value (rd_value[3]),
		.retire0_value   (rd_value[4]),
		.retire1_value   (rd_value[5]),
		.inst0_opa_valid (rd_valid[0]),
		.inst0_opb_valid (rd_valid[1]),
		.inst1_opa_valid (rd_valid[2]),
		.inst1_opb_valid (rd_valid[3]),
		.*
	);

	tb_prf_checks #(.PRF_SIZE(PRF_SIZE)) i_checks (.*);

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic logic hit(input logic valid, input logic [TAG_W-1:0] tag, input int idx);
		return valid && (tag == TAG_W'(idx));
	endfunction

	// rename hands out the lowest free entries, a lone slot 1 request takes the lowest
	always_comb
	begin
		int first;
		int second;
		first    = -1;
		second   = -1;
		exp_full = 1'b1;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (m_state[i] == ENTRY_FREE)
			begin
				exp_full = 1'b0;
				if (first < 0)
					first = i;
				else if (second < 0)
					second = i;
			end
		end
		exp_alloc0_valid = alloc_req0 && (first >= 0);
		exp_alloc0_tag   = TAG_W'(first);
		exp_alloc1_valid = alloc_req1 && ((alloc_req0 ? second : first) >= 0);
		exp_alloc1_tag   = TAG_W'(alloc_req0 ? second : first);
	end

	// ready entries give their value, anything else hands back its tag
	always_comb
	begin
		for (int p = 0; p < 6; p++)
			exp_value[p] = (m_state[rd_tag[p]] == ENTRY_READY) ? m_value[rd_tag[p]] : DATA_W'(rd_tag[p]);
		for (int p = 0; p < 4; p++)
			exp_valid[p] = (m_state[rd_tag[p]] == ENTRY_READY);
	end

	// free beats write, write beats allocation, the zero register never moves
	always @(posedge clock)
	begin
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (!rst_n)
			begin
				m_state[i] <= (i == ZERO_TAG) ? ENTRY_READY : ENTRY_FREE;
				m_value[i] <= '0;
			end
			else if (i != ZERO_TAG)
			begin
				if (hit(free0_valid, free0_tag, i) || hit(free1_valid, free1_tag, i)
					|| (flush_valid && flush_list[i]))
					m_state[i] <= ENTRY_FREE;
				else if (hit(cdb0_valid, cdb0_tag, i) || hit(cdb1_valid, cdb1_tag, i))
					m_state[i] <= ENTRY_READY;
				else if (hit(exp_alloc0_valid, exp_alloc0_tag, i)
					|| hit(exp_alloc1_valid, exp_alloc1_tag, i))
					m_state[i] <= ENTRY_PENDING;
				if (hit(cdb1_valid, cdb1_tag, i))
					m_value[i] <= cdb1_value;   // cdb1 wins a shared tag
				else if (hit(cdb0_valid, cdb0_tag, i))
					m_value[i] <= cdb0_value;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic int total_errors();
		return i_checks.errors + tb_errors;
	endfunction

	task automatic clear_strobes();
		alloc_req0  = 1'b0;
		alloc_req1  = 1'b0;
		cdb0_valid  = 1'b0;
		cdb1_valid  = 1'b0;
		free0_valid = 1'b0;
		free1_valid = 1'b0;
		flush_valid = 1'b0;
	endtask

	// strobes last one cycle, new inputs go out 10 ns after the edge
	task automatic next_cycle();
		@(posedge clock);
		#10;
		clear_strobes();
	endtask

	task automatic check_value(input logic [DATA_W-1:0] actual, input logic [DATA_W-1:0] expected,
		input string what);
		assert (actual === expected)
		else
		begin
			tb_errors++;
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic finish_test(input int num, input string name);
		int errs;
		errs            = total_errors() - errors_at_start;
		errors_at_start = total_errors();
		tests_done++;
		$display("test %0d (%s) finished with %0d errors", num, name, errs);
	endtask

	// requests both slots until the file reports full
	task automatic fill_file();
		int cycles;
		cycles = 0;
		while (!prf_full)
		begin
			if (cycles == FILL_TIMEOUT)
			begin
				$display("timeout: prf_full did not rise after %0d cycles of allocation", cycles);
				$display("SOME TESTS FAILED");
				$finish;
			end
			alloc_req0 = 1'b1;
			alloc_req1 = 1'b1;
			next_cycle();
			cycles++;
		end
	endtask

	task automatic drive_random_cycle();
		logic [TAG_W-1:0] tag;
		alloc_req0 = 1'($urandom_range(1));
		alloc_req1 = 1'($urandom_range(1));
		tag = TAG_W'($urandom_range(PRF_SIZE - 1));
		if (m_state[tag] != ENTRY_FREE)   // producers only write back renamed entries
		begin
			cdb0_valid = 1'b1;
			cdb0_tag   = tag;
			cdb0_value = DATA_W'({$urandom, $urandom});
		end
		// now and then both buses aim at one entry
		if (cdb0_valid && ($urandom_range(3) == 0))
			tag = cdb0_tag;
		else
			tag = TAG_W'($urandom_range(PRF_SIZE - 1));
		if (m_state[tag] != ENTRY_FREE)
		begin
			cdb1_valid = 1'b1;
			cdb1_tag   = tag;
			cdb1_value = DATA_W'({$urandom, $urandom});
		end
		tag = TAG_W'($urandom_range(PRF_SIZE - 1));
		if (($urandom_range(1) == 1) && (tag != ZERO_TAG))
		begin
			free0_valid = 1'b1;
			free0_tag   = tag;
		end
		tag = TAG_W'($urandom_range(PRF_SIZE - 1));
		if (($urandom_range(1) == 1) && (tag != ZERO_TAG))
		begin
			free1_valid = 1'b1;
			free1_tag   = tag;
		end
		if ($urandom_range(63) == 0)   // rare mispredict
		begin
			flush_valid          = 1'b1;
			flush_list           = PRF_SIZE'({$urandom, $urandom});
			flush_list[ZERO_TAG] = 1'b0;
		end
		for (int p = 0; p < 6; p++)
			rd_tag[p] = TAG_W'($urandom_range(PRF_SIZE - 1));
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [DATA_W-1:0] v0;
		logic [DATA_W-1:0] v1;
		void'($urandom(32'h896bc0e7));
		rst_n      = 1'b0;
		cdb0_tag   = '0;
		cdb0_value = '0;
		cdb1_tag   = '0;
		cdb1_value = '0;
		free0_tag  = '0;
		free1_tag  = '0;
		flush_list = '0;
		rd_tag     = '0;
		clear_strobes();
		repeat (8) @(posedge clock);
		#10;
		rst_n = 1'b1;

		// rename out of reset, the walk runs past the zero register at an even index
		next_cycle();
		@(negedge clock);
		check_value(prf_full, 0, "prf_full after reset");
		check_value(alloc0_valid, 0, "alloc0_valid after reset");
		check_value(alloc1_valid, 0, "alloc1_valid after reset");
		next_cycle();
		alloc_req0 = 1'b1;
		alloc_req1 = 1'b1;
		@(negedge clock);
		check_value(alloc0_tag, 0, "first slot 0 tag");
		check_value(alloc1_tag, 1, "first slot 1 tag");
		next_cycle();
		for (int n = 1; n < ZERO_TAG / 2; n++)
		begin
			alloc_req0 = 1'b1;
			alloc_req1 = 1'b1;
			next_cycle();
		end
		alloc_req0 = 1'b1;
		alloc_req1 = 1'b1;
		@(negedge clock);
		check_value(alloc0_tag, ZERO_TAG + 1, "slot 0 tag past the zero register");
		check_value(alloc1_tag, ZERO_TAG + 2, "slot 1 tag past the zero register");
		next_cycle();
		finish_test(1, "rename out of reset");

		// pending entries 2 and 3 on every port, then one write on each bus
		rd_tag = {TAG_W'(3), TAG_W'(2), TAG_W'(3), TAG_W'(2), TAG_W'(3), TAG_W'(2)};
		@(negedge clock);
		check_value(rd_valid[0], 0, "valid of a pending entry");
		check_value(rd_value[0], 2, "tag of a pending entry");
		next_cycle();
		v0         = DATA_W'({$urandom, $urandom});
		v1         = DATA_W'({$urandom, $urandom});
		cdb0_valid = 1'b1;
		cdb0_tag   = TAG_W'(2);
		cdb0_value = v0;
		cdb1_valid = 1'b1;
		cdb1_tag   = TAG_W'(3);
		cdb1_value = v1;
		@(negedge clock);
		check_value(rd_valid[1], 0, "valid in the write cycle");   // the write lands at the edge
		next_cycle();
		@(negedge clock);
		check_value(rd_value[4], v0, "retire read after cdb0 write");
		check_value(rd_value[5], v1, "retire read after cdb1 write");
		check_value(rd_valid[2], 1, "operand valid after write");
		next_cycle();
		finish_test(2, "bus write then read");

		rd_tag     = {6{TAG_W'(ZERO_TAG)}};
		cdb0_valid = 1'b1;
		cdb0_tag   = TAG_W'(ZERO_TAG);
		cdb0_value = DATA_W'({$urandom, $urandom});
		cdb1_valid = 1'b1;
		cdb1_tag   = TAG_W'(ZERO_TAG);
		cdb1_value = DATA_W'({$urandom, $urandom});
		next_cycle();
		@(negedge clock);
		check_value(rd_value[0], 0, "zero register value");
		check_value(rd_valid[3], 1, "zero register valid");
		check_value(rd_value[5], 0, "zero register on retire port");
		next_cycle();
		finish_test(3, "zero register");

		// entry 3 was written above, so its reuse must hide the old value
		free0_valid = 1'b1;
		free0_tag   = TAG_W'(3);
		free1_valid = 1'b1;
		free1_tag   = TAG_W'(5);
		rd_tag[0]   = TAG_W'(3);
		next_cycle();
		alloc_req0 = 1'b1;
		@(negedge clock);
		check_value(alloc0_tag, 3, "slot 0 after retire free");
		next_cycle();
		alloc_req1 = 1'b1;
		@(negedge clock);
		check_value(alloc1_tag, 5, "lone slot 1 after retire free");
		check_value(rd_valid[0], 0, "valid of a reused entry");
		next_cycle();
		finish_test(4, "retire free and reuse");

		fill_file();
		alloc_req0 = 1'b1;
		alloc_req1 = 1'b1;
		@(negedge clock);
		check_value(alloc0_valid, 0, "alloc0_valid when full");
		check_value(alloc1_valid, 0, "alloc1_valid when full");
		next_cycle();
		flush_valid          = 1'b1;
		flush_list           = PRF_SIZE'({$urandom, $urandom});
		flush_list[7]        = 1'b1;   // at least one entry comes back
		flush_list[ZERO_TAG] = 1'b0;
		next_cycle();
		@(negedge clock);
		check_value(prf_full, 0, "prf_full after flush");
		next_cycle();
		repeat (4)
		begin
			alloc_req0 = 1'b1;
			alloc_req1 = 1'b1;
			next_cycle();
		end
		finish_test(5, "full file and flush");

		repeat (RANDOM_CYCLES)
		begin
			drive_random_cycle();
			next_cycle();
		end
		@(negedge clock);
		finish_test(6, "random traffic");

		$display("tests run %0d, errors %0d", tests_done, total_errors());
		if (total_errors() == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* tb_prf_checks.sv */
// concurrent checks that hold every register file output equal to the reference model of tb_prf
`timescale 1ns/1ps

module tb_prf_checks #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE
) (
	input  logic                                  clock,
	input  logic                                  rst_n,
	input  logic                                  alloc0_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]           alloc0_tag,
	input  logic                                  alloc1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]           alloc1_tag,
	input  logic                                  prf_full,
	input  logic                                  exp_alloc0_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]           exp_alloc0_tag,
	input  logic                                  exp_alloc1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]           exp_alloc1_tag,
	input  logic                                  exp_full,
	input  logic [5:0][prf_cfg_pkg::DATA_W-1:0]   rd_value,    // four operand ports, then retire
	input  logic [3:0]                            rd_valid,    // operand ports only
	input  logic [5:0][prf_cfg_pkg::DATA_W-1:0]   exp_value,
	input  logic [3:0]                            exp_valid
);
	int errors = 0;   // summed by the testbench top after every test

	task automatic report_mismatch(input string what);
		errors++;
		$display("** Error at %0d ns: %s differs from the reference model", $time, what);
	endtask

	////////////////////////////////////////////////////////////
	// rename outputs
	////////////////////////////////////////////////////////////

	// a tag only matters while its slot is valid
	a_alloc0: assert property (@(posedge clock) disable iff (!rst_n)
		(alloc0_valid == exp_alloc0_valid) && (!exp_alloc0_valid || (alloc0_tag == exp_alloc0_tag)))
	else
		report_mismatch($sformatf("alloc slot 0 (tag %0d, model %0d)",
			$sampled(alloc0_tag), $sampled(exp_alloc0_tag)));

	a_alloc1: assert property (@(posedge clock) disable iff (!rst_n)
		(alloc1_valid == exp_alloc1_valid) && (!exp_alloc1_valid || (alloc1_tag == exp_alloc1_tag)))
	else
		report_mismatch($sformatf("alloc slot 1 (tag %0d, model %0d)",
			$sampled(alloc1_tag), $sampled(exp_alloc1_tag)));

	a_full: assert property (@(posedge clock) disable iff (!rst_n) prf_full == exp_full)
	else
		report_mismatch("prf_full");

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////

	for (genvar p = 0; p < 6; p++)
	begin : g_read_value
		a_value: assert property (@(posedge clock) disable iff (!rst_n)
			rd_value[p] == exp_value[p])
		else
			report_mismatch($sformatf("read port %0d value %0h (model %0h)", p,
				$sampled(rd_value[p]), $sampled(exp_value[p])));
	end

	// the retire ports carry no valid bit
	for (genvar p = 0; p < 4; p++)
	begin : g_read_valid
		a_valid: assert property (@(posedge clock) disable iff (!rst_n)
			rd_valid[p] == exp_valid[p])
		else
			report_mismatch($sformatf("read port %0d valid", p));
	end

endmodule

/* prf.sv */
// physical register file top, instantiate once per core and drive rename, writeback, retire and flush
`timescale 1ns/1ps

module prf #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE,
	parameter int ZERO_TAG = prf_cfg_pkg::ZERO_TAG
) (
	input  logic                            clock,
	input  logic                            rst_n,
	// rename
	input  logic                            alloc_req0,
	input  logic                            alloc_req1,
	output logic                            alloc0_valid,
	output logic [$clog2(PRF_SIZE)-1:0]     alloc0_tag,
	output logic                            alloc1_valid,
	output logic [$clog2(PRF_SIZE)-1:0]     alloc1_tag,
	output logic                            prf_full,
	// common data buses
	input  logic                            cdb0_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     cdb0_tag,
	input  logic [prf_cfg_pkg::DATA_W-1:0]  cdb0_value,
	input  logic                            cdb1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     cdb1_tag,
	input  logic [prf_cfg_pkg::DATA_W-1:0]  cdb1_value,
	// retire frees and mispredict recovery
	input  logic                            free0_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     free0_tag,
	input  logic                            free1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     free1_tag,
	input  logic                            flush_valid,
	input  logic [PRF_SIZE-1:0]             flush_list,
	// source operand reads
	input  logic [$clog2(PRF_SIZE)-1:0]     inst0_opa_tag,
	input  logic [$clog2(PRF_SIZE)-1:0]     inst0_opb_tag,
	input  logic [$clog2(PRF_SIZE)-1:0]     inst1_opa_tag,
	input  logic [$clog2(PRF_SIZE)-1:0]     inst1_opb_tag,
	output logic [prf_cfg_pkg::DATA_W-1:0]  inst0_opa_value,
	output logic                            inst0_opa_valid,
	output logic [prf_cfg_pkg::DATA_W-1:0]  inst0_opb_value,
	output logic                            inst0_opb_valid,
	output logic [prf_cfg_pkg::DATA_W-1:0]  inst1_opa_value,
	output logic                            inst1_opa_valid,
	output logic [prf_cfg_pkg::DATA_W-1:0]  inst1_opb_value,
	output logic                            inst1_opb_valid,
	// retire value reads
	input  logic [$clog2(PRF_SIZE)-1:0]     retire0_tag,
	input  logic [$clog2(PRF_SIZE)-1:0]     retire1_tag,
	output logic [prf_cfg_pkg::DATA_W-1:0]  retire0_value,
	output logic [prf_cfg_pkg::DATA_W-1:0]  retire1_value
);
	import prf_cfg_pkg::*;

	logic [PRF_SIZE-1:0]             entry_available;
	logic [PRF_SIZE-1:0]             entry_ready;
	logic [PRF_SIZE-1:0][DATA_W-1:0] entry_data;
	logic [PRF_SIZE-1:0]             entry_grant;
	logic [PRF_SIZE-1:0]             entry_free;

	////////////////////////////////////////////////////////////
	// entry array
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < PRF_SIZE; i++)
	begin : g_entry
		prf_entry #(
			.PRF_SIZE  (PRF_SIZE),
			.ENTRY_IDX (i),
			.IS_ZERO   (i == ZERO_TAG)   // exactly one hard-wired zero entry
		) i_entry (
			.clock      (clock),
			.rst_n      (rst_n),
			.grant      (entry_grant[i]),
			.free       (entry_free[i]),
			.cdb0_valid (cdb0_valid),
			.cdb0_tag   (cdb0_tag),
			.cdb0_value (cdb0_value),
			.cdb1_valid (cdb1_valid),
			.cdb1_tag   (cdb1_tag),
			.cdb1_value (cdb1_value),
			.available  (entry_available[i]),
			.ready      (entry_ready[i]),
			.data       (entry_data[i])
		);
	end

	// rename picks straight from the available vector
	prf_alloc #(.PRF_SIZE(PRF_SIZE)) i_alloc (
		.clock        (clock),
		.rst_n        (rst_n),
		.available    (entry_available),
		.alloc_req0   (alloc_req0),
		.alloc_req1   (alloc_req1),
		.grant        (entry_grant),
		.alloc0_valid (alloc0_valid),
		.alloc0_tag   (alloc0_tag),
		.alloc1_valid (alloc1_valid),
		.alloc1_tag   (alloc1_tag),
		.prf_full     (prf_full)
	);

	prf_free_ctrl #(.PRF_SIZE(PRF_SIZE)) i_free_ctrl (
		.clock       (clock),
		.rst_n       (rst_n),
		.free0_valid (free0_valid),
		.free0_tag   (free0_tag),
		.free1_valid (free1_valid),
		.free1_tag   (free1_tag),
		.flush_valid (flush_valid),
		.flush_list  (flush_list),
		.free        (entry_free)
	);

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////

	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_inst0_opa (
		.rd_tag (inst0_opa_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (inst0_opa_value),
		.valid  (inst0_opa_valid)
	);

	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_inst0_opb (
		.rd_tag (inst0_opb_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (inst0_opb_value),
		.valid  (inst0_opb_valid)
	);

	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_inst1_opa (
		.rd_tag (inst1_opa_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (inst1_opa_value),
		.valid  (inst1_opa_valid)
	);

	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_inst1_opb (
		.rd_tag (inst1_opb_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (inst1_opb_value),
		.valid  (inst1_opb_valid)
	);

	// retiring instructions are always written back, so their valid stays open
	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_retire0 (
		.rd_tag (retire0_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (retire0_value),
		.valid  ()
	);

	prf_read_port #(.PRF_SIZE(PRF_SIZE)) i_rd_retire1 (
		.rd_tag (retire1_tag),
		.ready  (entry_ready),
		.data   (entry_data),
		.value  (retire1_value),
		.valid  ()
	);

endmodule

/* prf_read_port.sv */
// one combinational read port, returns an entry's value or its tag when the value is not there yet
`timescale 1ns/1ps

module prf_read_port #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE
) (
	input  logic [$clog2(PRF_SIZE)-1:0]                    rd_tag,
	input  logic [PRF_SIZE-1:0]                            ready,   // per-entry ready bits
	input  logic [PRF_SIZE-1:0][prf_cfg_pkg::DATA_W-1:0]   data,    // all entry values
	output logic [prf_cfg_pkg::DATA_W-1:0]                 value,
	output logic                                           valid
);
	import prf_cfg_pkg::*;

	logic              sel_ready;
	logic [DATA_W-1:0] sel_data;

	// plain index mux, the zero register already reads as ready with value 0
	assign sel_ready = ready[rd_tag];
	assign sel_data  = data[rd_tag];

	always_comb
	begin
		if (sel_ready)
		begin
			value = sel_data;
			valid = 1'b1;
		end
		else
		begin
			// consumer keeps the tag and waits for it on the bus
			value = DATA_W'(rd_tag);
			valid = 1'b0;
		end
	end

endmodule

/* prf_free_ctrl.sv */
// builds the per-entry free vector from retire frees and the mispredict flush list
`timescale 1ns/1ps

module prf_free_ctrl #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        free0_valid,   // first retiring instruction
	input  logic [$clog2(PRF_SIZE)-1:0] free0_tag,
	input  logic                        free1_valid,   // second retiring instruction
	input  logic [$clog2(PRF_SIZE)-1:0] free1_tag,
	input  logic                        flush_valid,   // branch mispredict recovery
	input  logic [PRF_SIZE-1:0]         flush_list,
	output logic [PRF_SIZE-1:0]         free
);
	localparam int TAG_W = $clog2(PRF_SIZE);

	logic [PRF_SIZE-1:0] retire_free;

	// decode the two retire tags into one vector
	always_comb
	begin
		retire_free = '0;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (free0_valid && (free0_tag == TAG_W'(i)))
				retire_free[i] = 1'b1;
			if (free1_valid && (free1_tag == TAG_W'(i)))
				retire_free[i] = 1'b1;
		end
	end

	// the flush list already names every entry that is not architectural
	assign free = retire_free | ({PRF_SIZE{flush_valid}} & flush_list);

	////////////////////////////////////////////////////////////
	// input sanity
	////////////////////////////////////////////////////////////

	a_strobes_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown({free0_valid, free1_valid, flush_valid}));

	// payloads only matter while their strobe is up
	a_payload_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown({free0_valid ? free0_tag : '0,
			free1_valid ? free1_tag : '0,
			flush_valid ? flush_list : '0}));

endmodule

/* prf_alloc.sv */
// rename allocator, picks the two lowest free entries in one cycle and reports a full file
`timescale 1ns/1ps

module prf_alloc #(
	parameter int PRF_SIZE = prf_cfg_pkg::PRF_SIZE
) (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic [PRF_SIZE-1:0]         available,   // one bit per entry on the free list
	input  logic                        alloc_req0,
	input  logic                        alloc_req1,
	output logic [PRF_SIZE-1:0]         grant,       // one-hot per slot, merged
	output logic                        alloc0_valid,
	output logic [$clog2(PRF_SIZE)-1:0] alloc0_tag,
	output logic                        alloc1_valid,
	output logic [$clog2(PRF_SIZE)-1:0] alloc1_tag,
	output logic                        prf_full
);
	import prf_state_pkg::*;

	localparam int TAG_W = $clog2(PRF_SIZE);

	alloc_mode_e         mode;
	logic [PRF_SIZE-1:0] pick0;        // lowest free entry
	logic [PRF_SIZE-1:0] avail_rest;   // free entries with pick0 masked out
	logic [PRF_SIZE-1:0] pick1;        // next lowest free entry

	// one-hot to index, at most one bit is ever set here
	function automatic logic [TAG_W-1:0] encode(input logic [PRF_SIZE-1:0] onehot);
		logic [TAG_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < PRF_SIZE; i++)
		begin
			if (onehot[i])
				idx = idx | TAG_W'(i);
		end
		return idx;
	endfunction

	assign mode = alloc_mode_e'({alloc_req1, alloc_req0});

	////////////////////////////////////////////////////////////
	// chained priority picks
	////////////////////////////////////////////////////////////

	// x & -x isolates the lowest set bit
	assign pick0      = available & (~available + PRF_SIZE'(1));
	assign avail_rest = available & ~pick0;
	assign pick1      = avail_rest & (~avail_rest + PRF_SIZE'(1));

	always_comb
	begin
		grant        = '0;
		alloc0_valid = 1'b0;
		alloc0_tag   = '0;
		alloc1_valid = 1'b0;
		alloc1_tag   = '0;
		case (mode)
			ALLOC_SLOT0:
			begin
				grant        = pick0;
				alloc0_valid = |pick0;
				alloc0_tag   = encode(pick0);
			end
			ALLOC_SLOT1:
			begin
				// a lone second request still takes the lowest entry
				grant        = pick0;
				alloc1_valid = |pick0;
				alloc1_tag   = encode(pick0);
			end
			ALLOC_BOTH:
			begin
				grant        = pick0 | pick1;
				alloc0_valid = |pick0;
				alloc0_tag   = encode(pick0);
				alloc1_valid = |pick1;   // drops when only one entry is left
				alloc1_tag   = encode(pick1);
			end
			default:
			begin
				grant = '0;   // no request, nothing leaves the free list
			end
		endcase
	end

	assign prf_full = ~|available;

	// the entries see at most two renames per edge
	a_grant_max_two: assert property (@(posedge clock) disable iff (!rst_n)
		$countones(grant) <= 2);

	// two destinations in one cycle must never share a physical entry
	a_tags_differ: assert property (@(posedge clock) disable iff (!rst_n)
		(alloc0_valid && alloc1_valid) |-> (alloc0_tag != alloc1_tag));

endmodule

/* prf_entry.sv */
// one physical register entry with its own state, data and bus-write match, replicated by prf
`timescale 1ns/1ps

module prf_entry #(
	parameter int PRF_SIZE  = prf_cfg_pkg::PRF_SIZE,
	parameter int ENTRY_IDX = 0,
	parameter bit IS_ZERO   = 1'b0
) (
	input  logic                            clock,
	input  logic                            rst_n,
	input  logic                            grant,        // allocator picked this entry
	input  logic                            free,         // retire free or flush hit
	input  logic                            cdb0_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     cdb0_tag,
	input  logic [prf_cfg_pkg::DATA_W-1:0]  cdb0_value,
	input  logic                            cdb1_valid,
	input  logic [$clog2(PRF_SIZE)-1:0]     cdb1_tag,
	input  logic [prf_cfg_pkg::DATA_W-1:0]  cdb1_value,
	output logic                            available,    // entry sits on the free list
	output logic                            ready,        // value can be forwarded
	output logic [prf_cfg_pkg::DATA_W-1:0]  data
);
	import prf_cfg_pkg::*;
	import prf_state_pkg::*;

	localparam int TAG_W = $clog2(PRF_SIZE);
	// the zero register comes out of reset already holding its value
	localparam entry_state_e RESET_STATE = IS_ZERO ? ENTRY_READY : ENTRY_FREE;

	entry_state_e      state_q;
	logic [DATA_W-1:0] data_q;
	logic              cdb0_hit;
	logic              cdb1_hit;
	logic              wr_hit;
	logic [DATA_W-1:0] wr_value;

	// each entry compares the bus tags against its own index
	assign cdb0_hit = cdb0_valid && (cdb0_tag == TAG_W'(ENTRY_IDX));
	assign cdb1_hit = cdb1_valid && (cdb1_tag == TAG_W'(ENTRY_IDX));
	assign wr_hit   = cdb0_hit || cdb1_hit;
	assign wr_value = cdb1_hit ? cdb1_value : cdb0_value;   // cdb1 wins a tag collision

	////////////////////////////////////////////////////////////
	// state update
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			state_q <= RESET_STATE;
		else if (IS_ZERO)
			state_q <= ENTRY_READY;         // hard-wired entry ignores every event
		else if (free)
			state_q <= ENTRY_FREE;          // a free beats a write in the same cycle
		else if (wr_hit)
			state_q <= ENTRY_READY;         // and a write beats an allocation
		else if (grant)
			state_q <= ENTRY_PENDING;
	end

	// payload only moves on a bus hit
	always_ff @(posedge clock)
	begin
		if (wr_hit && !IS_ZERO)
			data_q <= wr_value;
	end

	assign available = (state_q == ENTRY_FREE);
	assign ready     = (state_q == ENTRY_READY);
	assign data      = IS_ZERO ? '0 : data_q;   // zero register never exposes stored bits

	// a producer only writes back to a tag that rename handed out earlier
	a_no_write_to_free: assert property (@(posedge clock) disable iff (!rst_n)
		wr_hit |-> (state_q != ENTRY_FREE));

endmodule

/* prf_state_pkg.sv */
// enum types for the entry life cycle and the decoded rename request, shared by RTL and testbench
package prf_state_pkg;

	// life cycle of one physical entry
	// free entries can be handed out by rename, pending ones wait on a bus write
	typedef enum logic [1:0]
	{
		ENTRY_FREE    = 2'b00,   // on the free list
		ENTRY_PENDING = 2'b01,   // renamed, producer has not written back yet
		ENTRY_READY   = 2'b10    // value is valid and can be read by consumers
	} entry_state_e;

	// the two rename requests packed as {req1, req0}
	typedef enum logic [1:0]
	{
		ALLOC_NONE  = 2'b00,   // nothing to rename this cycle
		ALLOC_SLOT0 = 2'b01,   // only the first destination
		ALLOC_SLOT1 = 2'b10,   // only the second destination
		ALLOC_BOTH  = 2'b11    // two destinations in the same cycle
	} alloc_mode_e;

	// one spare state is left in entry_state_e
	// the entry logic never enters it

endpackage

/* prf_cfg_pkg.sv */
// size constants for the physical register file that every RTL module and the testbench import
package prf_cfg_pkg;

	//////////////////////////////////////////////////////////
	// register file geometry
	//////////////////////////////////////////////////////////

	// number of physical entries and the default size of the top level
	localparam int PRF_SIZE = 64;

	localparam int DATA_W = 64;   // width of one register value

	// tag of the hard-wired zero register
	// it reads as zero, is always ready and never leaves that state
	localparam int ZERO_TAG = 48;

endpackage
